//--- dma_retry.f
rtl/dma_retry_pkg.sv
rtl/dma_pipe_if.sv
rtl/dma_admit.sv
rtl/dma_valid_lookup.sv
rtl/dma_issue_decide.sv
rtl/dma_rsp_merge.sv
rtl/dma_retry_top.sv
tb/dma_retry_checker.sv
tb/tb_dma_retry.sv

//--- rtl/dma_admit.sv
`timescale 1ns/1ps
`default_nettype none

module dma_admit
   import dma_retry_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [0:CRED_W-1]  i_init_credits,
   input  logic               i_req_v,
   input  logic [0:TAG_W-1]   i_req_tag,
   input  logic [0:CTXT_W-1]  i_req_ctxt,
   input  logic               i_req_tstag_v,
   input  logic [0:TSTAG_W-1] i_req_tstag,
   input  logic [0:DAT_W-1]   i_req_dat,
   input  logic               i_ctxt_add_v,
   input  logic               i_ctxt_trm_v,
   input  logic [0:CTXT_W-1]  i_ctxt_id,
   input  logic               i_rsp_v,
   input  logic [0:CRED_W-1]  i_rsp_credits,
   input  logic               i_cred_ret,
   output logic               o_req_rdy,
   output logic               o_ctxt_rdy,
   output logic [0:CRED_W-1]  o_credits,
   dma_pipe_if.src            o_pipe
);

   logic              v_q;
   logic              is_ctrl_q;
   logic [0:CTXT_W-1] ctxt_q;
   pipe_word_u        w_q;
   logic [0:CRED_W-1] cred_q;
   logic [0:CRED_W-1] rsp_add;
   logic              load;
   logic              cmd_v;
   logic              req_acc;
   pipe_word_u        word;

   // the stage register takes a new word whenever its current one leaves
   assign load    = ~v_q | o_pipe.r;
   assign cmd_v   = i_ctxt_add_v | i_ctxt_trm_v;

   // commands win, so a request waits while one is pending
   assign o_ctxt_rdy = load;
   assign o_req_rdy  = load & ~cmd_v & (cred_q != '0);
   assign req_acc    = i_req_v & o_req_rdy;

   always_comb begin
      word = '0;
      if (cmd_v) begin
         word.ctrl.op = i_ctxt_add_v ? CTRL_ADD : CTRL_TRM;
      end else begin
         word.req.tag     = i_req_tag;
         word.req.tstag_v = i_req_tstag_v;
         word.req.tstag   = i_req_tstag;
         word.req.dat     = i_req_dat;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         v_q <= 1'b0;
      end else if (load) begin
         v_q <= cmd_v | req_acc;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         is_ctrl_q <= cmd_v;
         ctxt_q    <= cmd_v ? i_ctxt_id : i_req_ctxt;
         w_q       <= word;
      end
   end

   // refills, abort returns and the spend on admission all land in one cycle
   assign rsp_add = i_rsp_v ? i_rsp_credits : '0;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cred_q <= i_init_credits;
      end else begin
         cred_q <= cred_q + rsp_add + CRED_W'(i_cred_ret) - CRED_W'(req_acc);
      end
   end

   assign o_credits = cred_q;

   assign o_pipe.v        = v_q;
   assign o_pipe.is_ctrl  = is_ctrl_q;
   assign o_pipe.ctxt     = ctxt_q;
   assign o_pipe.w        = w_q;
   assign o_pipe.ctxt_vld = 1'b0;
   assign o_pipe.ts_vld   = 1'b0;

endmodule

`default_nettype wire

//--- rtl/dma_issue_decide.sv
`timescale 1ns/1ps
`default_nettype none

module dma_issue_decide
   import dma_retry_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_req_rdy,
   input  logic              i_abort_rdy,
   dma_pipe_if.dst           i_pipe,
   output logic              o_req_v,
   output logic [0:TAG_W-1]  o_req_tag,
   output logic [0:CTXT_W-1] o_req_ctxt,
   output logic [0:DAT_W-1]  o_req_dat,
   output logic              o_abort_v,
   output logic [0:TAG_W-1]  o_abort_tag,
   output logic [0:RC_W-1]   o_abort_rc,
   output logic              o_cred_ret,
   output logic              o_ctxt_add_v,
   output logic              o_ctxt_trm_v,
   output logic [0:CTXT_W-1] o_ctxt_trm_id
);

   logic              req_v_q;
   logic              abort_v_q;
   logic              add_v_q;
   logic              trm_v_q;
   logic [0:TAG_W-1]  tag_q;
   logic [0:CTXT_W-1] ctxt_q;
   logic [0:DAT_W-1]  dat_q;
   logic [0:RC_W-1]   rc_q;
   logic [0:RC_W-1]   rc;
   logic              abort;
   logic              is_req;
   logic              load;

   // a bad timestamp tag is reported ahead of a bad context
   always_comb begin
      if (i_pipe.w.req.tstag_v && !i_pipe.ts_vld) begin
         rc = RC_TSINV;
      end else if (!i_pipe.ctxt_vld) begin
         rc = RC_CTXT;
      end else begin
         rc = RC_OK;
      end
   end

   assign abort  = (rc != RC_OK);
   assign is_req = i_pipe.v & ~i_pipe.is_ctrl;

   // command pulses always leave after one cycle and never block the stage
   assign load = (~req_v_q & ~abort_v_q) | (req_v_q & i_req_rdy) | (abort_v_q & i_abort_rdy);
   assign i_pipe.r = load;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         req_v_q   <= 1'b0;
         abort_v_q <= 1'b0;
         add_v_q   <= 1'b0;
         trm_v_q   <= 1'b0;
      end else if (load) begin
         req_v_q   <= is_req & ~abort;
         abort_v_q <= is_req & abort;
         add_v_q   <= i_pipe.v & i_pipe.is_ctrl & (i_pipe.w.ctrl.op == CTRL_ADD);
         trm_v_q   <= i_pipe.v & i_pipe.is_ctrl & (i_pipe.w.ctrl.op == CTRL_TRM);
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         tag_q  <= i_pipe.w.req.tag;
         ctxt_q <= i_pipe.ctxt;
         dat_q  <= i_pipe.w.req.dat;
         rc_q   <= rc;
      end
   end

   assign o_req_v    = req_v_q;
   assign o_req_tag  = tag_q;
   assign o_req_ctxt = ctxt_q;
   assign o_req_dat  = dat_q;

   assign o_abort_v   = abort_v_q;
   assign o_abort_tag = tag_q;
   assign o_abort_rc  = rc_q;

   // the aborted request gives its credit back once the response port takes it
   assign o_cred_ret = abort_v_q & i_abort_rdy;

   assign o_ctxt_add_v  = add_v_q;
   assign o_ctxt_trm_v  = trm_v_q;
   assign o_ctxt_trm_id = ctxt_q;

endmodule

`default_nettype wire

//--- rtl/dma_pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

// one valid/ready hop between two pipeline stages
interface dma_pipe_if
   import dma_retry_pkg::*;
   ();

   logic              v;
   logic              r;
   logic              is_ctrl;
   logic [0:CTXT_W-1] ctxt;
   pipe_word_u        w;

   // the valid table stage fills in these lookup results
   logic              ctxt_vld;
   logic              ts_vld;

   modport src (output v, is_ctrl, ctxt, w, ctxt_vld, ts_vld, input r);
   modport dst (input v, is_ctrl, ctxt, w, ctxt_vld, ts_vld, output r);

endinterface

`default_nettype wire

//--- rtl/dma_retry_pkg.sv
`default_nettype none

package dma_retry_pkg;

   localparam int TAG_W   = 4;
   localparam int CTXT_W  = 3;
   localparam int TSTAG_W = 3;
   localparam int DAT_W   = 16;
   localparam int RC_W    = 8;
   localparam int CRED_W  = 5;
   localparam int N_CTXT  = 8;
   localparam int N_TSTAG = 8;

   // width of the word that travels down the pipeline
   localparam int PIPE_W = TAG_W + 1 + TSTAG_W + DAT_W;

   localparam logic [0:RC_W-1] RC_OK    = 8'h00;
   localparam logic [0:RC_W-1] RC_CRED  = 8'h09;
   localparam logic [0:RC_W-1] RC_TSINV = 8'h81;
   localparam logic [0:RC_W-1] RC_CTXT  = 8'h0b;

   localparam logic CTRL_ADD = 1'b0;
   localparam logic CTRL_TRM = 1'b1;

   typedef struct packed {
      logic [0:TAG_W-1]   tag;
      logic               tstag_v;
      logic [0:TSTAG_W-1] tstag;
      logic [0:DAT_W-1]   dat;
   } req_fields_t;

   // a context command only needs its op, the rest of the word is unused
   typedef struct packed {
      logic              op;
      logic [0:PIPE_W-2] pad;
   } ctrl_fields_t;

   // is_ctrl next to the word selects which view is live
   typedef union packed {
      req_fields_t  req;
      ctrl_fields_t ctrl;
   } pipe_word_u;

endpackage

`default_nettype wire

//--- rtl/dma_retry_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_retry_top
   import dma_retry_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [0:CRED_W-1]  i_init_credits,
   input  logic               i_req_v,
   input  logic [0:TAG_W-1]   i_req_tag,
   input  logic [0:CTXT_W-1]  i_req_ctxt,
   input  logic               i_req_tstag_v,
   input  logic [0:TSTAG_W-1] i_req_tstag,
   input  logic [0:DAT_W-1]   i_req_dat,
   input  logic               i_req_rdy,
   input  logic               i_ctxt_add_v,
   input  logic               i_ctxt_trm_v,
   input  logic [0:CTXT_W-1]  i_ctxt_id,
   input  logic               i_tstag_issue_v,
   input  logic [0:TSTAG_W-1] i_tstag_issue_id,
   input  logic               i_tstag_inv_v,
   input  logic [0:TSTAG_W-1] i_tstag_inv_id,
   input  logic               i_rsp_v,
   input  logic [0:RC_W-1]    i_rsp_d,
   input  logic [0:TAG_W-1]   i_rsp_tag,
   input  logic [0:CRED_W-1]  i_rsp_credits,
   output logic               o_req_rdy,
   output logic               o_req_v,
   output logic [0:TAG_W-1]   o_req_tag,
   output logic [0:CTXT_W-1]  o_req_ctxt,
   output logic [0:DAT_W-1]   o_req_dat,
   output logic               o_ctxt_rdy,
   output logic               o_ctxt_add_v,
   output logic               o_ctxt_trm_v,
   output logic [0:CTXT_W-1]  o_ctxt_trm_id,
   output logic               o_rsp_v,
   output logic [0:TAG_W-1]   o_rsp_tag,
   output logic [0:RC_W-1]    o_rsp_d,
   output logic [0:CRED_W-1]  o_credits
);

   logic             cred_ret;
   logic             abort_v;
   logic             abort_rdy;
   logic [0:TAG_W-1] abort_tag;
   logic [0:RC_W-1]  abort_rc;

   dma_pipe_if a_to_l ();
   dma_pipe_if l_to_d ();

   // requests and context commands share one ordered path through these stages
   dma_admit dma_admit_inst (
      .i_clk, .i_rst, .i_init_credits,
      .i_req_v, .i_req_tag, .i_req_ctxt, .i_req_tstag_v, .i_req_tstag, .i_req_dat,
      .i_ctxt_add_v, .i_ctxt_trm_v, .i_ctxt_id,
      .i_rsp_v, .i_rsp_credits,
      .i_cred_ret (cred_ret),
      .o_req_rdy, .o_ctxt_rdy, .o_credits,
      .o_pipe     (a_to_l.src)
   );

   dma_valid_lookup dma_valid_lookup_inst (
      .i_clk, .i_rst,
      .i_tstag_issue_v, .i_tstag_issue_id, .i_tstag_inv_v, .i_tstag_inv_id,
      .i_pipe (a_to_l.dst),
      .o_pipe (l_to_d.src)
   );

   dma_issue_decide dma_issue_decide_inst (
      .i_clk, .i_rst, .i_req_rdy,
      .i_abort_rdy (abort_rdy),
      .i_pipe      (l_to_d.dst),
      .o_req_v, .o_req_tag, .o_req_ctxt, .o_req_dat,
      .o_abort_v   (abort_v),
      .o_abort_tag (abort_tag),
      .o_abort_rc  (abort_rc),
      .o_cred_ret  (cred_ret),
      .o_ctxt_add_v, .o_ctxt_trm_v, .o_ctxt_trm_id
   );

   // inbound responses bypass the request pipe and go straight to the merge
   dma_rsp_merge dma_rsp_merge_inst (
      .i_clk, .i_rst,
      .i_rsp_v, .i_rsp_d, .i_rsp_tag,
      .i_abort_v   (abort_v),
      .i_abort_tag (abort_tag),
      .i_abort_rc  (abort_rc),
      .o_abort_rdy (abort_rdy),
      .o_rsp_v, .o_rsp_tag, .o_rsp_d
   );

endmodule

`default_nettype wire

//--- rtl/dma_rsp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rsp_merge
   import dma_retry_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_rsp_v,
   input  logic [0:RC_W-1]  i_rsp_d,
   input  logic [0:TAG_W-1] i_rsp_tag,
   input  logic             i_abort_v,
   input  logic [0:TAG_W-1] i_abort_tag,
   input  logic [0:RC_W-1]  i_abort_rc,
   output logic             o_abort_rdy,
   output logic             o_rsp_v,
   output logic [0:TAG_W-1] o_rsp_tag,
   output logic [0:RC_W-1]  o_rsp_d
);

   logic             in_v;
   logic             rsp_v_q;
   logic [0:TAG_W-1] tag_q;
   logic [0:RC_W-1]  d_q;

   // credit-only responses just refill the counter and are not forwarded
   assign in_v = i_rsp_v & (i_rsp_d != RC_CRED);

   // the inbound response cannot stall, so an abort waits for a free cycle
   assign o_abort_rdy = ~in_v;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rsp_v_q <= 1'b0;
      end else begin
         rsp_v_q <= in_v | i_abort_v;
      end
   end

   always_ff @(posedge i_clk) begin
      tag_q <= in_v ? i_rsp_tag : i_abort_tag;
      d_q   <= in_v ? i_rsp_d : i_abort_rc;
   end

   assign o_rsp_v   = rsp_v_q;
   assign o_rsp_tag = tag_q;
   assign o_rsp_d   = d_q;

endmodule

`default_nettype wire

//--- rtl/dma_valid_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dma_valid_lookup
   import dma_retry_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_tstag_issue_v,
   input  logic [0:TSTAG_W-1] i_tstag_issue_id,
   input  logic               i_tstag_inv_v,
   input  logic [0:TSTAG_W-1] i_tstag_inv_id,
   dma_pipe_if.dst            i_pipe,
   dma_pipe_if.src            o_pipe
);

   logic [0:N_CTXT-1]  ctxt_tbl;
   logic [0:N_TSTAG-1] ts_tbl;
   logic               v_q;
   logic               is_ctrl_q;
   logic [0:CTXT_W-1]  ctxt_q;
   pipe_word_u         w_q;
   logic               ctxt_vld_q;
   logic               ts_vld_q;
   logic               load;
   logic               ctrl_take;

   assign load      = ~v_q | o_pipe.r;
   assign i_pipe.r  = load;
   assign ctrl_take = i_pipe.v & load & i_pipe.is_ctrl;

   // a command updates the table as it passes, so any request behind it
   // is looked up against the new state
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ctxt_tbl <= '0;
      end else if (ctrl_take) begin
         ctxt_tbl[i_pipe.ctxt] <= (i_pipe.w.ctrl.op == CTRL_ADD);
      end
   end

   // invalidate is applied last and wins over an issue to the same tag
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ts_tbl <= '0;
      end else begin
         if (i_tstag_issue_v) begin
            ts_tbl[i_tstag_issue_id] <= 1'b1;
         end
         if (i_tstag_inv_v) begin
            ts_tbl[i_tstag_inv_id] <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         v_q <= 1'b0;
      end else if (load) begin
         v_q <= i_pipe.v;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         is_ctrl_q  <= i_pipe.is_ctrl;
         ctxt_q     <= i_pipe.ctxt;
         w_q        <= i_pipe.w;
         ctxt_vld_q <= ctxt_tbl[i_pipe.ctxt];
         ts_vld_q   <= ts_tbl[i_pipe.w.req.tstag];
      end
   end

   assign o_pipe.v        = v_q;
   assign o_pipe.is_ctrl  = is_ctrl_q;
   assign o_pipe.ctxt     = ctxt_q;
   assign o_pipe.w        = w_q;
   assign o_pipe.ctxt_vld = ctxt_vld_q;
   assign o_pipe.ts_vld   = ts_vld_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the DMA retry filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_dma_retry -f dma_retry.f -o sim_dma_retry

out=$(./obj_dir/sim_dma_retry)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
else
   exit 1
fi

//--- tb/dma_retry_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the DUT ports and compares them against a cycle-level model
module dma_retry_checker
   import dma_retry_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [0:CRED_W-1]  i_init_credits,
   input  logic               i_req_v,
   input  logic [0:TAG_W-1]   i_req_tag,
   input  logic [0:CTXT_W-1]  i_req_ctxt,
   input  logic               i_req_tstag_v,
   input  logic [0:TSTAG_W-1] i_req_tstag,
   input  logic [0:DAT_W-1]   i_req_dat,
   input  logic               i_req_rdy,
   input  logic               i_ctxt_add_v,
   input  logic               i_ctxt_trm_v,
   input  logic [0:CTXT_W-1]  i_ctxt_id,
   input  logic               i_tstag_issue_v,
   input  logic [0:TSTAG_W-1] i_tstag_issue_id,
   input  logic               i_tstag_inv_v,
   input  logic [0:TSTAG_W-1] i_tstag_inv_id,
   input  logic               i_rsp_v,
   input  logic [0:RC_W-1]    i_rsp_d,
   input  logic [0:TAG_W-1]   i_rsp_tag,
   input  logic [0:CRED_W-1]  i_rsp_credits,
   input  logic               i_dut_req_rdy,
   input  logic               i_dut_req_v,
   input  logic [0:TAG_W-1]   i_dut_req_tag,
   input  logic [0:CTXT_W-1]  i_dut_req_ctxt,
   input  logic [0:DAT_W-1]   i_dut_req_dat,
   input  logic               i_dut_ctxt_rdy,
   input  logic               i_dut_ctxt_add_v,
   input  logic               i_dut_ctxt_trm_v,
   input  logic [0:CTXT_W-1]  i_dut_ctxt_trm_id,
   input  logic               i_dut_rsp_v,
   input  logic [0:TAG_W-1]   i_dut_rsp_tag,
   input  logic [0:RC_W-1]    i_dut_rsp_d,
   input  logic [0:CRED_W-1]  i_dut_credits,
   output int unsigned        o_pending,
   output int unsigned        o_val_errs,
   output int unsigned        o_other_errs
);

   // a stream entry is {kind, tag, ctxt, dat} where kind 0 is a request,
   // 1 an add and 2 a terminate
   logic [24:0]        stream_q[$];
   // abort entry is {tag, rc}
   logic [11:0]        abort_q[$];
   logic [0:N_CTXT-1]  ctxt_m;
   logic [0:N_TSTAG-1] ts_m;
   logic [0:CRED_W-1]  cred_m;
   logic               in_exp;
   logic [0:TAG_W-1]   in_tag;
   logic [0:RC_W-1]    in_d;

   initial begin
      o_val_errs   = 0;
      o_other_errs = 0;
      o_pending    = 0;
   end

   task automatic value_check(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
         o_val_errs++;
      end
   endtask

   task automatic other_error(input string what);
      $display("%0t %s", $time, what);
      o_other_errs++;
   endtask

   always @(posedge i_clk) begin : check_edge
      logic [24:0]     e;
      logic [11:0]     a;
      logic [0:RC_W-1] rc;
      if (i_rst) begin
         stream_q.delete();
         abort_q.delete();
         ctxt_m = '0;
         ts_m   = '0;
         cred_m = i_init_credits;
         in_exp = 1'b0;
      end else begin
         // the response port shows what was loaded on the previous edge
         if (in_exp) begin
            if (!i_dut_rsp_v) begin
               other_error("inbound response was not forwarded");
            end else begin
               value_check("o_rsp_tag", 32'(i_dut_rsp_tag), 32'(in_tag));
               value_check("o_rsp_d", 32'(i_dut_rsp_d), 32'(in_d));
            end
         end else if (i_dut_rsp_v) begin
            if (abort_q.size() == 0) begin
               other_error("response appeared with nothing expected");
            end else begin
               a = abort_q.pop_front();
               value_check("o_rsp_tag", 32'(i_dut_rsp_tag), 32'(a[11:8]));
               value_check("o_rsp_d", 32'(i_dut_rsp_d), 32'(a[7:0]));
               // the credit came back on the edge that loaded this abort
               cred_m = cred_m + CRED_W'(1);
            end
         end

         value_check("o_credits", 32'(i_dut_credits), 32'(cred_m));
         if (i_dut_credits == '0 && i_dut_req_rdy) begin
            other_error("request ready while no credits are left");
         end
         if ((i_ctxt_add_v || i_ctxt_trm_v) && i_dut_req_rdy) begin
            other_error("request ready while a context command is pending");
         end

         if (i_dut_req_v && i_req_rdy) begin
            if (stream_q.size() == 0 || stream_q[0][24:23] != 2'd0) begin
               other_error("request issued out of order or unexpectedly");
            end else begin
               e = stream_q.pop_front();
               value_check("o_req_tag", 32'(i_dut_req_tag), 32'(e[22:19]));
               value_check("o_req_ctxt", 32'(i_dut_req_ctxt), 32'(e[18:16]));
               value_check("o_req_dat", 32'(i_dut_req_dat), 32'(e[15:0]));
            end
         end
         if (i_dut_ctxt_add_v) begin
            if (stream_q.size() == 0 || stream_q[0][24:23] != 2'd1) begin
               other_error("context add pulse out of order or unexpected");
            end else begin
               e = stream_q.pop_front();
            end
         end
         if (i_dut_ctxt_trm_v) begin
            if (stream_q.size() == 0 || stream_q[0][24:23] != 2'd2) begin
               other_error("terminate pulse out of order or unexpected");
            end else begin
               e = stream_q.pop_front();
               value_check("o_ctxt_trm_id", 32'(i_dut_ctxt_trm_id), 32'(e[18:16]));
            end
         end

         // with nothing left in flight every stage is free to take a word
         if (stream_q.size() == 0 && abort_q.size() == 0) begin
            if (!i_dut_ctxt_rdy) begin
               other_error("context commands not ready while the pipeline is empty");
            end
            if (!i_dut_req_rdy && !i_ctxt_add_v && !i_ctxt_trm_v && i_dut_credits != '0) begin
               other_error("requests not ready while the pipeline is empty");
            end
         end

         // now apply what this edge accepts
         in_exp = i_rsp_v && (i_rsp_d != RC_CRED);
         in_tag = i_rsp_tag;
         in_d   = i_rsp_d;
         if (i_rsp_v) begin
            cred_m = cred_m + i_rsp_credits;
         end

         if ((i_ctxt_add_v || i_ctxt_trm_v) && i_dut_ctxt_rdy) begin
            ctxt_m[i_ctxt_id] = i_ctxt_add_v;
            stream_q.push_back({i_ctxt_add_v ? 2'd1 : 2'd2, TAG_W'(0), i_ctxt_id,
                                DAT_W'(0)});
         end else if (i_req_v && i_dut_req_rdy) begin
            cred_m = cred_m - CRED_W'(1);
            if (i_req_tstag_v && !ts_m[i_req_tstag]) begin
               rc = RC_TSINV;
            end else if (!ctxt_m[i_req_ctxt]) begin
               rc = RC_CTXT;
            end else begin
               rc = RC_OK;
            end
            if (rc == RC_OK) begin
               stream_q.push_back({2'd0, i_req_tag, i_req_ctxt, i_req_dat});
            end else begin
               abort_q.push_back({i_req_tag, rc});
            end
         end

         if (i_tstag_issue_v) begin
            ts_m[i_tstag_issue_id] = 1'b1;
         end
         if (i_tstag_inv_v) begin
            ts_m[i_tstag_inv_id] = 1'b0;
         end
      end
      o_pending = stream_q.size() + abort_q.size() + (in_exp ? 1 : 0);
   end

endmodule

`default_nettype wire

//--- tb/tb_dma_retry.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_retry
   import dma_retry_pkg::*;
();

   logic               i_clk;
   logic               i_rst;
   logic [0:CRED_W-1]  i_init_credits;
   logic               i_req_v;
   logic [0:TAG_W-1]   i_req_tag;
   logic [0:CTXT_W-1]  i_req_ctxt;
   logic               i_req_tstag_v;
   logic [0:TSTAG_W-1] i_req_tstag;
   logic [0:DAT_W-1]   i_req_dat;
   logic               i_req_rdy;
   logic               i_ctxt_add_v;
   logic               i_ctxt_trm_v;
   logic [0:CTXT_W-1]  i_ctxt_id;
   logic               i_tstag_issue_v;
   logic [0:TSTAG_W-1] i_tstag_issue_id;
   logic               i_tstag_inv_v;
   logic [0:TSTAG_W-1] i_tstag_inv_id;
   logic               i_rsp_v;
   logic [0:RC_W-1]    i_rsp_d;
   logic [0:TAG_W-1]   i_rsp_tag;
   logic [0:CRED_W-1]  i_rsp_credits;
   logic               o_req_rdy;
   logic               o_req_v;
   logic [0:TAG_W-1]   o_req_tag;
   logic [0:CTXT_W-1]  o_req_ctxt;
   logic [0:DAT_W-1]   o_req_dat;
   logic               o_ctxt_rdy;
   logic               o_ctxt_add_v;
   logic               o_ctxt_trm_v;
   logic [0:CTXT_W-1]  o_ctxt_trm_id;
   logic               o_rsp_v;
   logic [0:TAG_W-1]   o_rsp_tag;
   logic [0:RC_W-1]    o_rsp_d;
   logic [0:CRED_W-1]  o_credits;
   int unsigned        pending;
   int unsigned        val_errs;
   int unsigned        other_errs;
   bit                 timed_out;

   dma_retry_top dma_retry_top_inst (.*);

   dma_retry_checker dma_retry_checker_inst (
      .i_clk, .i_rst, .i_init_credits,
      .i_req_v, .i_req_tag, .i_req_ctxt, .i_req_tstag_v, .i_req_tstag, .i_req_dat,
      .i_req_rdy, .i_ctxt_add_v, .i_ctxt_trm_v, .i_ctxt_id,
      .i_tstag_issue_v, .i_tstag_issue_id, .i_tstag_inv_v, .i_tstag_inv_id,
      .i_rsp_v, .i_rsp_d, .i_rsp_tag, .i_rsp_credits,
      .i_dut_req_rdy (o_req_rdy),
      .i_dut_req_v (o_req_v),
      .i_dut_req_tag (o_req_tag),
      .i_dut_req_ctxt (o_req_ctxt),
      .i_dut_req_dat (o_req_dat),
      .i_dut_ctxt_rdy (o_ctxt_rdy),
      .i_dut_ctxt_add_v (o_ctxt_add_v),
      .i_dut_ctxt_trm_v (o_ctxt_trm_v),
      .i_dut_ctxt_trm_id (o_ctxt_trm_id),
      .i_dut_rsp_v (o_rsp_v),
      .i_dut_rsp_tag (o_rsp_tag),
      .i_dut_rsp_d (o_rsp_d),
      .i_dut_credits (o_credits),
      .o_pending (pending),
      .o_val_errs (val_errs),
      .o_other_errs (other_errs)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   task automatic drive_idle();
      i_req_v          = 1'b0;
      i_req_tag        = '0;
      i_req_ctxt       = '0;
      i_req_tstag_v    = 1'b0;
      i_req_tstag      = '0;
      i_req_dat        = '0;
      i_req_rdy        = 1'b1;
      i_ctxt_add_v     = 1'b0;
      i_ctxt_trm_v     = 1'b0;
      i_ctxt_id        = '0;
      i_tstag_issue_v  = 1'b0;
      i_tstag_issue_id = '0;
      i_tstag_inv_v    = 1'b0;
      i_tstag_inv_id   = '0;
      i_rsp_v          = 1'b0;
      i_rsp_d          = '0;
      i_rsp_tag        = '0;
      i_rsp_credits    = '0;
   endtask

   task automatic drive_random();
      int unsigned r;
      r = $urandom % 100;
      i_ctxt_add_v  = (r < 6);
      i_ctxt_trm_v  = (r >= 6) && (r < 9);
      i_ctxt_id     = CTXT_W'($urandom);
      i_req_v       = ($urandom % 100) < 40;
      i_req_tag     = TAG_W'($urandom);
      i_req_ctxt    = CTXT_W'($urandom);
      i_req_tstag_v = ($urandom % 4) == 0;
      i_req_tstag   = TSTAG_W'($urandom);
      i_req_dat     = DAT_W'($urandom);
      i_req_rdy     = ($urandom % 100) < 75;
      i_rsp_v       = ($urandom % 100) < 15;
      i_rsp_d       = (($urandom % 3) == 0) ? RC_CRED : RC_W'($urandom);
      i_rsp_tag     = TAG_W'($urandom);
      i_rsp_credits = CRED_W'($urandom % 3);
   endtask

   // waits for an empty pipe, then flips one timestamp tag
   task automatic update_tstag(output bit to);
      int unsigned cnt;
      to  = 1'b0;
      cnt = 0;
      drive_idle();
      while (pending != 0 && cnt < 200) begin
         @(posedge i_clk);
         #1;
         cnt++;
      end
      if (pending != 0) begin
         to = 1'b1;
      end else begin
         if (($urandom % 3) != 0) begin
            i_tstag_issue_v  = 1'b1;
            i_tstag_issue_id = TSTAG_W'($urandom);
         end else begin
            i_tstag_inv_v  = 1'b1;
            i_tstag_inv_id = TSTAG_W'($urandom);
         end
         @(posedge i_clk);
         #1;
         drive_idle();
         repeat (2) @(posedge i_clk);
         #1;
      end
   endtask

   initial begin
      int unsigned cnt;
      timed_out = 1'b0;
      void'($urandom(32'h82fd));
      drive_idle();
      i_rst          = 1'b1;
      i_init_credits = CRED_W'(6);
      repeat (5) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      for (int n = 0; n < 3000 && !timed_out; n++) begin
         if (n % 150 == 149) begin
            update_tstag(timed_out);
         end else begin
            drive_random();
            @(posedge i_clk);
            #1;
         end
      end
      drive_idle();
      cnt = 0;
      while (pending != 0 && cnt < 200) begin
         @(posedge i_clk);
         #1;
         cnt++;
      end
      if (pending != 0) begin
         timed_out = 1'b1;
      end
      if (timed_out) begin
         $display("timeout while waiting for the DUT to drain its pipeline");
      end
      $display("errors: %0d value, %0d other", val_errs, other_errs);
      if (timed_out || val_errs != 0 || other_errs != 0) begin
         $display("Test failed");
      end else begin
         $display("Test completed successfully");
      end
      $finish;
   end

endmodule

`default_nettype wire
